// ==== vlog.f ====
rv_core_pkg.sv
wb_bus_pkg.sv
gpr_file.sv
store_master.sv
wb_stage.sv
retire_top.sv
tb_clock_gen.sv
tb_retire_top.sv

// ==== Bender.yml ====
package:
  name: rv_retire

sources:
  - rv_core_pkg.sv
  - wb_bus_pkg.sv
  - gpr_file.sv
  - store_master.sv
  - wb_stage.sv
  - retire_top.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_retire_top.sv

// ==== tb_retire_top.sv ====
`timescale 1ns/1ps

module tb_retire_top;

    localparam int n_ext      = 24;
    localparam int n_store    = 6;
    localparam int n_blocked  = 10;
    localparam int n_ops      = 32 + 2 * (n_ext + 1) + 2 + 3 * n_store + 2 + n_blocked;
    localparam int op_cycles  = 10; // bundle, 3 waits, ack, follow-up, margin
    localparam int timeout_ns = (12 + n_ops * op_cycles) * 8;

    logic                        clk;
    logic                        rst_n;
    rv_core_pkg::retire_bundle_t in_bundle;
    wb_bus_pkg::wb_rsp_t         bus_rsp;
    rv_core_pkg::reg_idx_t       dbg_idx;
    logic                        in_ready;
    wb_bus_pkg::wb_req_t         bus_req;
    rv_core_pkg::retire_rec_t    retire;
    logic                        halted;
    logic [63:0]                 dbg_data;

    logic [31:0]                 lfsr_state = 32'h0d95c9ce;
    logic [63:0]                 shadow [32];       // expected register contents
    logic [7:0]                  mem [logic [63:0]]; // slave memory, byte addressed
    wb_bus_pkg::wb_req_t         exp_req_q [$];
    logic [63:0]                 exp_pc_q [$];
    rv_core_pkg::retire_rec_t    exp_rec;
    time                         accept_time;
    time                         ack_time = 0;

    tb_clock_gen i_clock_gen (.clk(clk), .rst_n(rst_n));

    retire_top #(.num_regs(32)) i_retire_top (.*);

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic logic [63:0] draw_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[62:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic [63:0] expected_ext(input rv_core_pkg::ext_e ext,
                                                 input logic [63:0] v);
        case (ext)
            rv_core_pkg::ext_word_s: return longint'(int'(v[31:0]));
            rv_core_pkg::ext_word_z: return {32'h0, v[31:0]};
            rv_core_pkg::ext_half_s: return longint'(shortint'(v[15:0]));
            default:                 return v;
        endcase
    endfunction

    task automatic stop_run();
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic fail_plain(input string what);
        $display("%0d ns: %s", $time, what);
        stop_run();
    endtask

    task automatic check_flag(input string name, input logic exp, input logic got);
        if (got !== exp) begin
            $display("ERROR at %0d ns: %s expected %b, got %b", $time, name, exp, got);
            stop_run();
        end
    endtask

    task automatic check_data(input string name, input logic [63:0] exp, input logic [63:0] got);
        if (got !== exp) begin
            $display("ERROR at %0d ns: %s expected %h, got %h", $time, name, exp, got);
            stop_run();
        end
    endtask

    task automatic check_retire(input string name, input rv_core_pkg::retire_rec_t exp,
                                input rv_core_pkg::retire_rec_t got);
        if (got !== exp) begin
            $display("ERROR at %0d ns: %s expected valid=%b pc=%h, got valid=%b pc=%h",
                     $time, name, exp.valid, exp.pc, got.valid, got.pc);
            stop_run();
        end
    endtask

    task automatic check_bus_req(input string name, input wb_bus_pkg::wb_req_t exp,
                                 input wb_bus_pkg::wb_req_t got);
        if (got !== exp) begin
            $display("ERROR at %0d ns: %s expected cyc/stb/we=%b%b%b adr=%h dat=%h sel=%h",
                     $time, name, exp.cyc, exp.stb, exp.we, exp.adr, exp.dat, exp.sel);
            $display("    got cyc/stb/we=%b%b%b adr=%h dat=%h sel=%h",
                     got.cyc, got.stb, got.we, got.adr, got.dat, got.sel);
            stop_run();
        end
    endtask

    // entered and left 1 ns after a rising edge
    task automatic send_bundle(input rv_core_pkg::retire_bundle_t b);
        in_bundle       = b;
        in_bundle.valid = 1'b1;
        @(negedge clk);
        while (!in_ready) @(negedge clk);
        @(posedge clk); // transfer edge
        accept_time = $time;
        exp_pc_q.push_back(b.pc);
        #1;
        in_bundle = '0;
    endtask

    task automatic read_gpr(input int idx, output logic [63:0] val);
        dbg_idx = 5'(idx);
        @(negedge clk);
        val = dbg_data;
        @(posedge clk);
        #1;
    endtask

    task automatic offer_blocked(input rv_core_pkg::retire_bundle_t b, input int cycles);
        in_bundle       = b;
        in_bundle.valid = 1'b1;
        repeat (cycles) begin
            @(negedge clk);
            check_flag("in_ready", 1'b0, in_ready);
            check_flag("halted", 1'b1, halted);
        end
        @(posedge clk);
        #1;
        in_bundle = '0;
    endtask

    task automatic reset_test();
        logic [63:0] got;
        @(negedge clk);
        check_flag("in_ready", 1'b1, in_ready);
        check_flag("bus_req.cyc", 1'b0, bus_req.cyc);
        check_flag("bus_req.stb", 1'b0, bus_req.stb);
        check_flag("retire.valid", 1'b0, retire.valid);
        check_flag("halted", 1'b0, halted);
        @(posedge clk);
        #1;
        for (int r = 0; r < 32; r++) begin
            read_gpr(r, got);
            check_data($sformatf("x%0d", r), 64'h0, got);
        end
    endtask

    task automatic extension_test();
        rv_core_pkg::retire_bundle_t b;
        logic [63:0]                 got;
        for (int i = 0; i <= n_ext; i++) begin
            b          = '0;
            b.rd       = (i == n_ext) ? 5'd0 : 5'(1 + (i * 7) % 31); // last one hits x0
            b.rd_wen   = 1'b1;
            b.ext      = rv_core_pkg::ext_e'(i % 4);
            b.src      = rv_core_pkg::src_e'((i / 4) % 2);
            b.alu_res  = draw_bits(64);
            b.load_res = draw_bits(64);
            b.pc       = 64'h1000 + 64'(4 * i);
            send_bundle(b);
            if (b.rd != 0) begin
                shadow[b.rd] = expected_ext(b.ext,
                    (b.src == rv_core_pkg::src_load) ? b.load_res : b.alu_res);
            end
            read_gpr(b.rd, got);
            check_data($sformatf("x%0d", b.rd), shadow[b.rd], got);
        end
    endtask

    task automatic store_test();
        int                          offsets [n_store] = '{64, -64, 2040, -2048, 512, -1000};
        logic [7:0]                  masks [n_store] = '{8'hff, 8'h0f, 8'hf0, 8'h01, 8'h3c, 8'h80};
        logic [63:0]                 alu_v [n_store];
        logic [63:0]                 load_v [n_store];
        logic [63:0]                 adr;
        logic [63:0]                 got;
        rv_core_pkg::retire_bundle_t b;
        wb_bus_pkg::wb_req_t         req;
        for (int k = 0; k < n_store; k++) begin
            alu_v[k]  = draw_bits(64);
            load_v[k] = draw_bits(64);
        end
        b         = '0;
        b.rd      = 5'd10; // base register
        b.rd_wen  = 1'b1;
        b.alu_res = 64'h0000_0000_8000_0000;
        b.pc      = 64'h2000;
        send_bundle(b);
        shadow[10] = b.alu_res;
        read_gpr(10, got);
        check_data("x10", shadow[10], got);
        for (int k = 0; k < n_store; k++) begin
            b          = '0;
            b.rd       = 5'd10;
            b.rd_wen   = 1'b1; // a store still must not overwrite its base
            b.is_store = 1'b1;
            b.ext      = rv_core_pkg::ext_e'(k % 4);
            b.src      = rv_core_pkg::src_e'(k % 2);
            b.alu_res  = alu_v[k];
            b.load_res = load_v[k];
            b.offset   = offsets[k];
            b.wmask    = masks[k];
            b.pc       = 64'h2100 + 64'(4 * k);
            adr = shadow[10] + longint'(offsets[k]);
            req = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: adr, sel: masks[k],
                    dat: expected_ext(b.ext, (k % 2 == 1) ? load_v[k] : alu_v[k])};
            exp_req_q.push_back(req);
            send_bundle(b);
            // offered at once, has to wait behind the open bus cycle
            b         = '0;
            b.rd      = 5'(11 + k);
            b.rd_wen  = 1'b1;
            b.alu_res = alu_v[k] ^ load_v[k];
            b.pc      = 64'h2200 + 64'(4 * k);
            send_bundle(b);
            shadow[11 + k] = b.alu_res;
            if (accept_time != ack_time + 8) begin
                fail_plain($sformatf("bundle taken at %0d ns, not in the cycle after ack at %0d ns",
                                     accept_time, ack_time));
            end
            for (int i = 0; i < 8; i++) begin
                if (!masks[k][i] && mem.exists(adr + i)) begin
                    fail_plain($sformatf("byte %h written although its sel bit is low", adr + i));
                end else if (masks[k][i] && !mem.exists(adr + i)) begin
                    fail_plain($sformatf("byte %h never written by the store", adr + i));
                end else if (masks[k][i]) begin
                    check_data($sformatf("mem[%h]", adr + i), 64'(req.dat[8*i +: 8]),
                               64'(mem[adr + i]));
                end
            end
            read_gpr(11 + k, got);
            check_data($sformatf("x%0d", 11 + k), shadow[11 + k], got);
        end
    endtask

    task automatic ebreak_test();
        rv_core_pkg::retire_bundle_t b;
        logic [63:0]                 got;
        b           = '0;
        b.rd        = 5'd5; // rd_wen low, x5 keeps its value
        b.alu_res   = ~shadow[5];
        b.is_ebreak = 1'b1;
        b.pc        = 64'h3000;
        send_bundle(b);
        @(negedge clk);
        check_flag("halted", 1'b1, halted);
        check_flag("in_ready", 1'b0, in_ready);
        @(posedge clk);
        #1;
        b         = '0;
        b.rd      = 5'd5;
        b.rd_wen  = 1'b1;
        b.alu_res = ~shadow[5];
        b.pc      = 64'h3004;
        offer_blocked(b, n_blocked);
        read_gpr(5, got);
        check_data("x5", shadow[5], got);
    endtask

    // wishbone slave, acks after 0 to 3 wait cycles
    initial begin
        wb_bus_pkg::wb_req_t exp;
        wb_bus_pkg::wb_req_t cur;
        int                  waits;
        bus_rsp = '0;
        forever begin
            @(posedge clk);
            #1;
            if (rst_n && bus_req.cyc && bus_req.stb) begin
                if (exp_req_q.size() == 0) begin
                    fail_plain("bus cycle opened with no store pending");
                end
                exp   = exp_req_q.pop_front();
                waits = int'(draw_bits(2));
                check_bus_req("bus_req", exp, bus_req);
                check_flag("in_ready", 1'b0, in_ready);
                repeat (waits) begin
                    @(posedge clk);
                    #1;
                    check_bus_req("bus_req", exp, bus_req);
                    check_flag("in_ready", 1'b0, in_ready);
                end
                cur         = bus_req;
                bus_rsp.ack = 1'b1;
                @(posedge clk); // ack edge
                ack_time = $time;
                for (int i = 0; i < 8; i++) begin
                    if (cur.sel[i]) begin
                        mem[cur.adr + i] = cur.dat[8*i +: 8];
                    end
                end
                #1;
                bus_rsp.ack = 1'b0;
                check_flag("bus_req.cyc", 1'b0, bus_req.cyc);
                check_flag("in_ready", 1'b1, in_ready);
            end
        end
    end

    // one retire pulse per accepted bundle, none otherwise
    always @(negedge clk) begin
        if (rst_n && retire.valid) begin
            if (exp_pc_q.size() == 0) begin
                fail_plain("retire pulse with no bundle accepted");
            end else begin
                exp_rec.valid = 1'b1;
                exp_rec.pc    = exp_pc_q.pop_front();
                check_retire("retire", exp_rec, retire);
            end
        end else if (rst_n && exp_pc_q.size() != 0) begin
            fail_plain("no retire pulse after an accepted bundle");
        end
    end

    initial begin
        #(timeout_ns);
        $display("watchdog expired after %0d ns, the run did not finish", timeout_ns);
        stop_run();
    end

    initial begin
        in_bundle = '0;
        dbg_idx   = '0;
        for (int r = 0; r < 32; r++) begin
            shadow[r] = '0;
        end
        wait (rst_n === 1'b1);
        reset_test();
        extension_test();
        store_test();
        ebreak_test();
        repeat (2) @(negedge clk);
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int period_ns    = 8,
    parameter int reset_cycles = 8
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    // release 1 ns after an edge, same as all other stimulus
    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #1;
        rst_n = 1'b1;
    end

endmodule

// ==== retire_top.sv ====
`timescale 1ns/1ps

module retire_top #(
    parameter int num_regs = 32
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  rv_core_pkg::retire_bundle_t  in_bundle,
    input  wb_bus_pkg::wb_rsp_t          bus_rsp,
    input  rv_core_pkg::reg_idx_t        dbg_idx,
    output logic                         in_ready,
    output wb_bus_pkg::wb_req_t          bus_req,
    output rv_core_pkg::retire_rec_t     retire,
    output logic                         halted,
    output logic [63:0]                  dbg_data
);

    logic                  wr_en;
    rv_core_pkg::reg_idx_t wr_idx;
    logic [63:0]           wr_data;
    rv_core_pkg::reg_idx_t rd_idx;
    logic [63:0]           rd_data;
    logic                  st_go;
    logic [63:0]           st_adr;
    logic [63:0]           st_dat;
    logic [7:0]            st_sel;
    logic                  st_busy;

    wb_stage #(
        .num_regs (num_regs)
    ) i_wb_stage (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_bundle (in_bundle),
        .rd_data   (rd_data),
        .st_busy   (st_busy),
        .in_ready  (in_ready),
        .wr_en     (wr_en),
        .wr_idx    (wr_idx),
        .wr_data   (wr_data),
        .rd_idx    (rd_idx),
        .st_go     (st_go),
        .st_adr    (st_adr),
        .st_dat    (st_dat),
        .st_sel    (st_sel),
        .retire    (retire),
        .halted    (halted)
    );

    gpr_file #(
        .num_regs (num_regs)
    ) i_gpr_file (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_en    (wr_en),
        .wr_idx   (wr_idx),
        .wr_data  (wr_data),
        .rd_idx   (rd_idx),
        .dbg_idx  (dbg_idx),
        .rd_data  (rd_data),
        .dbg_data (dbg_data)
    );

    store_master i_store_master (
        .clk     (clk),
        .rst_n   (rst_n),
        .st_go   (st_go),
        .st_adr  (st_adr),
        .st_dat  (st_dat),
        .st_sel  (st_sel),
        .bus_rsp (bus_rsp),
        .st_busy (st_busy),
        .bus_req (bus_req)
    );

endmodule

// ==== wb_stage.sv ====
`timescale 1ns/1ps

module wb_stage #(
    parameter int num_regs = 32
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  rv_core_pkg::retire_bundle_t  in_bundle,
    input  logic [63:0]                  rd_data,
    input  logic                         st_busy,
    output logic                         in_ready,
    output logic                         wr_en,
    output rv_core_pkg::reg_idx_t        wr_idx,
    output logic [63:0]                  wr_data,
    output rv_core_pkg::reg_idx_t        rd_idx,
    output logic                         st_go,
    output logic [63:0]                  st_adr,
    output logic [63:0]                  st_dat,
    output logic [7:0]                   st_sel,
    output rv_core_pkg::retire_rec_t     retire,
    output logic                         halted
);

    logic                         accept;
    logic [rv_core_pkg::xlen-1:0] sel_res;
    logic [rv_core_pkg::xlen-1:0] ext_res;
    logic                         halted_q;
    logic                         ret_vld_q;
    logic [rv_core_pkg::xlen-1:0] ret_pc_q;

    assign in_ready = !st_busy && !halted_q; // one store in flight at most
    assign accept   = in_bundle.valid && in_ready;

    assign sel_res = (in_bundle.src == rv_core_pkg::src_load) ? in_bundle.load_res
                                                               : in_bundle.alu_res;

    always_comb begin
        case (in_bundle.ext)
            rv_core_pkg::ext_word_s: ext_res = {{32{sel_res[31]}}, sel_res[31:0]};
            rv_core_pkg::ext_word_z: ext_res = {32'b0, sel_res[31:0]};
            rv_core_pkg::ext_half_s: ext_res = {{48{sel_res[15]}}, sel_res[15:0]};
            default:                 ext_res = sel_res; // ext_dword
        endcase
    end

    // indices past num_regs do not exist on RV64E and retire without a write
    assign wr_en   = accept && in_bundle.rd_wen && !in_bundle.is_store
                     && (in_bundle.rd < num_regs);
    assign wr_idx  = in_bundle.rd;
    assign wr_data = ext_res;

    // store address is base register + sign-extended immediate
    assign rd_idx = in_bundle.rd;
    assign st_go  = accept && in_bundle.is_store;
    assign st_adr = rd_data + {{32{in_bundle.offset[31]}}, in_bundle.offset};
    assign st_dat = ext_res;
    assign st_sel = in_bundle.wmask;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            halted_q  <= 1'b0;
            ret_vld_q <= 1'b0;
        end else begin
            ret_vld_q <= accept;
            if (accept && in_bundle.is_ebreak) begin
                halted_q <= 1'b1; // sticky until reset
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            ret_pc_q <= in_bundle.pc;
        end
    end

    assign retire = '{valid: ret_vld_q, pc: ret_pc_q};
    assign halted = halted_q;

endmodule

// ==== store_master.sv ====
`timescale 1ns/1ps

module store_master (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  st_go,
    input  logic [63:0]           st_adr,
    input  logic [63:0]           st_dat,
    input  logic [7:0]            st_sel,
    input  wb_bus_pkg::wb_rsp_t   bus_rsp,
    output logic                  st_busy,
    output wb_bus_pkg::wb_req_t   bus_req
);

    logic                          cyc_q;
    logic [wb_bus_pkg::adr_w-1:0]  adr_q;
    logic [wb_bus_pkg::dat_w-1:0]  dat_q;
    logic [wb_bus_pkg::sel_w-1:0]  sel_q;

    // open the cycle one edge after st_go, close on the ack edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cyc_q <= 1'b0;
        end else if (st_go) begin
            cyc_q <= 1'b1;
        end else if (cyc_q && bus_rsp.ack) begin
            cyc_q <= 1'b0;
        end
    end

    // bus lines are kept at zero until the first store
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            adr_q <= '0;
            dat_q <= '0;
            sel_q <= '0;
        end else if (st_go) begin
            adr_q <= st_adr;
            dat_q <= st_dat;
            sel_q <= st_sel;
        end
    end

    assign st_busy = cyc_q;

    always_comb begin
        bus_req.cyc = cyc_q;
        bus_req.stb = cyc_q; // classic, stb follows cyc
        bus_req.we  = cyc_q; // write-only master
        bus_req.adr = adr_q;
        bus_req.dat = dat_q;
        bus_req.sel = sel_q;
    end

    a_stb_cyc: assert property (
        @(posedge clk) disable iff (!rst_n)
        bus_req.stb |-> bus_req.cyc
    ) else $error("store_master: stb without cyc");

    // request must hold still while the slave inserts wait states
    a_req_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        (bus_req.stb && !bus_rsp.ack) |=>
            ($stable(bus_req.adr) && $stable(bus_req.dat) && $stable(bus_req.sel))
    ) else $error("store_master: request changed before ack");

    // upstream back-pressure must keep launches out of an open cycle
    a_go_idle: assert property (
        @(posedge clk) disable iff (!rst_n)
        st_go |-> !st_busy
    ) else $error("store_master: st_go while busy");

endmodule

// ==== gpr_file.sv ====
`timescale 1ns/1ps

module gpr_file #(
    parameter int num_regs = 32
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   wr_en,
    input  rv_core_pkg::reg_idx_t  wr_idx,
    input  logic [63:0]            wr_data,
    input  rv_core_pkg::reg_idx_t  rd_idx,
    input  rv_core_pkg::reg_idx_t  dbg_idx,
    output logic [63:0]            rd_data,
    output logic [63:0]            dbg_data
);

    logic [63:0] regs [num_regs];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_idx != '0) begin // x0 never written
            regs[wr_idx] <= wr_data;
        end
    end

    // both reads are combinational, x0 and out-of-range read zero
    always_comb begin
        if (rd_idx == '0 || rd_idx >= num_regs) begin
            rd_data = '0;
        end else begin
            rd_data = regs[rd_idx];
        end
    end

    always_comb begin
        if (dbg_idx == '0 || dbg_idx >= num_regs) begin
            dbg_data = '0;
        end else begin
            dbg_data = regs[dbg_idx];
        end
    end

    // stage must filter indices beyond the configured register count (RV64E)
    a_wr_idx_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        wr_en |-> (wr_idx < num_regs)
    ) else $error("gpr_file: write index %0d out of range", wr_idx);

endmodule

// ==== wb_bus_pkg.sv ====
package wb_bus_pkg;

    parameter int unsigned adr_w = 64;
    parameter int unsigned dat_w = 64;
    parameter int unsigned sel_w = dat_w / 8;

    // master to slave
    typedef struct packed {
        logic             cyc;
        logic             stb;
        logic             we;
        logic [adr_w-1:0] adr;
        logic [dat_w-1:0] dat;
        logic [sel_w-1:0] sel;
    } wb_req_t;

    // slave to master, read data only kept for bus shape
    typedef struct packed {
        logic             ack;
        logic [dat_w-1:0] dat;
    } wb_rsp_t;

endpackage

// ==== rv_core_pkg.sv ====
package rv_core_pkg;

    parameter int unsigned xlen = 64;

    typedef logic [4:0] reg_idx_t;

    // how the selected result is widened to xlen
    typedef enum logic [1:0] {
        ext_dword  = 2'd0, // keep all 64 bits
        ext_word_s = 2'd1, // sign-extend bits 31:0
        ext_word_z = 2'd2, // zero-extend bits 31:0
        ext_half_s = 2'd3  // sign-extend bits 15:0
    } ext_e;

    typedef enum logic {
        src_alu  = 1'b0,
        src_load = 1'b1
    } src_e;

    // one retiring instruction as handed over by the memory stage
    typedef struct packed {
        logic              valid;
        reg_idx_t          rd;        // dest, or store base register
        logic              rd_wen;
        logic              is_store;
        logic              is_ebreak;
        ext_e              ext;
        src_e              src;
        logic [xlen-1:0]   alu_res;
        logic [xlen-1:0]   load_res;
        logic signed [31:0] offset;   // store immediate
        logic [7:0]        wmask;
        logic [xlen-1:0]   pc;
    } retire_bundle_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
    } retire_rec_t;

endpackage
